// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = fetch_tb
FLIST   = flist.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/imem_rd_if.sv
hdl/pc_unit.sv
hdl/fetch_fsm.sv
hdl/imem_latency_timer.sv
hdl/imem_rom.sv
hdl/fetch_top.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

// File: hdl/fetch_defs.svh
// Fetch stage parameters
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Width of the PC, the jump targets and the read channel
`define FETCH_DATA_WIDTH 32

// Program counter after reset and the sequential step
`define FETCH_RESET_PC 32'h8000_0000
`define FETCH_PC_STEP 32'd4

// Fixed trap target, one word
`define FETCH_TRAP_VEC 32'h8000_0100

// Instruction memory depth in words, based at the reset PC
`define FETCH_IMEM_WORDS 256

// Cycles from address accept to rvalid
`define FETCH_IMEM_LATENCY 3

`define FETCH_EBREAK 32'h0010_0073

`endif

// File: hdl/fetch_fsm.sv
// Instruction fetch control
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_fsm (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         pc_wen,
  input  logic [`FETCH_DATA_WIDTH-1:0] pc,
  imem_rd_if.fetch                     rd,
  output logic [31:0]                  inst,
  output logic                         inst_valid,
  input  logic                         idu_ready,
  output logic                         halt
);

  fetch_pkg::fetch_state_e state_q;
  logic [31:0] inst_buf;
  logic ar_hs;
  logic r_hs;
  logic is_ebreak;

  assign ar_hs     = rd.arvalid && rd.arready;
  assign r_hs      = rd.rvalid && rd.rready;
  assign is_ebreak = (inst_buf == `FETCH_EBREAK);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= fetch_pkg::FETCH_REQ;
      rd.arvalid <= 1'b0;
      rd.rready  <= 1'b0;
    end else begin
      case (state_q)
        fetch_pkg::IDLE: begin
          // Wait for write-back to pick the next PC
          if (pc_wen) begin
            state_q <= fetch_pkg::FETCH_REQ;
          end
        end

        fetch_pkg::FETCH_REQ: begin
          if (ar_hs) begin
            rd.arvalid <= 1'b0;
            rd.rready  <= 1'b1;
            state_q    <= fetch_pkg::FETCH_WAIT;
          end else begin
            rd.arvalid <= 1'b1;
          end
        end

        fetch_pkg::FETCH_WAIT: begin
          if (r_hs) begin
            rd.rready <= 1'b0;
            state_q   <= fetch_pkg::FETCH_DONE;
          end
        end

        fetch_pkg::FETCH_DONE: begin
          // ebreak is still handed over before stopping
          if (idu_ready) begin
            state_q <= is_ebreak ? fetch_pkg::HALTED : fetch_pkg::IDLE;
          end
        end

        fetch_pkg::HALTED: begin
          state_q <= fetch_pkg::HALTED;
        end

        default: begin
          state_q    <= fetch_pkg::IDLE;
          rd.arvalid <= 1'b0;
          rd.rready  <= 1'b0;
        end
      endcase
    end
  end

  // Instruction buffer
  always_ff @(posedge clk) begin
    if (r_hs) begin
      inst_buf <= rd.rdata;
    end
  end

  assign rd.araddr  = pc;
  assign inst       = inst_buf;
  assign inst_valid = (state_q == fetch_pkg::FETCH_DONE);
  assign halt       = (state_q == fetch_pkg::HALTED);

  arvalid_only_in_req_a : assert property (
    @(posedge clk) disable iff (rst)
    rd.arvalid |-> state_q == fetch_pkg::FETCH_REQ
  ) else $error("fetch_fsm: arvalid high in state %s", state_q.name());

  // Decoder side must see a stable word under back-pressure
  inst_hold_a : assert property (
    @(posedge clk) disable iff (rst)
    inst_valid && !idu_ready |=> inst_valid && $stable(inst)
  ) else $error("fetch_fsm: inst changed before acceptance");

endmodule

// File: hdl/fetch_pkg.sv
// Fetch stage types
package fetch_pkg;

  // Next PC source, encoded as the write-back select bus
  typedef enum logic [2:0] {
    PC_SEQ  = 3'd0,
    PC_JALR = 3'd1,
    PC_BR   = 3'd2,
    PC_JAL  = 3'd3,
    PC_TRAP = 3'd4
  } pc_sel_e;

  // Fetch control states
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    FETCH_REQ  = 3'd1,
    FETCH_WAIT = 3'd2,
    FETCH_DONE = 3'd3,
    HALTED     = 3'd4
  } fetch_state_e;

endpackage

// File: hdl/fetch_top.sv
// Fetch stage with instruction memory
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_top (
  input  logic                         clk,
  input  logic                         rst,
  // Next PC select from decode and write-back
  input  fetch_pkg::pc_sel_e           pc_sel,
  input  logic [`FETCH_DATA_WIDTH-1:0] jump_reg_target,
  input  logic [`FETCH_DATA_WIDTH-1:0] br_target,
  input  logic [`FETCH_DATA_WIDTH-1:0] jmp_target,
  input  logic                         pc_wen,
  // Program load, used during reset
  input  logic                         load_en,
  input  logic [7:0]                   load_addr,
  input  logic [31:0]                  load_data,
  // Decoder side
  input  logic                         idu_ready,
  output logic [`FETCH_DATA_WIDTH-1:0] pc,
  output logic [31:0]                  inst,
  output logic                         inst_valid,
  output logic                         halt
);

  logic [`FETCH_DATA_WIDTH-1:0] pc_cur;

  imem_rd_if rd_bus ();

  pc_unit pc_i (
    .clk             (clk),
    .rst             (rst),
    .pc_wen          (pc_wen),
    .pc_sel          (pc_sel),
    .jump_reg_target (jump_reg_target),
    .br_target       (br_target),
    .jmp_target      (jmp_target),
    .pc              (pc_cur)
  );

  fetch_fsm fsm_i (
    .clk        (clk),
    .rst        (rst),
    .pc_wen     (pc_wen),
    .pc         (pc_cur),
    .rd         (rd_bus),
    .inst       (inst),
    .inst_valid (inst_valid),
    .idu_ready  (idu_ready),
    .halt       (halt)
  );

  imem_rom imem_i (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd        (rd_bus)
  );

  assign pc = pc_cur;

endmodule

// File: hdl/imem_latency_timer.sv
// Memory read latency counter
`timescale 1ns/1ps
`include "fetch_defs.svh"

module imem_latency_timer (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic ack,
  output logic done
);

  localparam int CNT_W = $clog2(`FETCH_IMEM_LATENCY + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             active_q;

  // active_q spans the whole count and the held done
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
    end else if (start) begin
      cnt_q    <= CNT_W'(`FETCH_IMEM_LATENCY);
      active_q <= 1'b1;
    end else if (done && ack) begin
      active_q <= 1'b0;
    end else if (active_q && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign done = active_q && (cnt_q == '0);

  // The memory must only start a read when the previous one is finished
  start_when_idle_a : assert property (
    @(posedge clk) disable iff (rst)
    start |-> !active_q
  ) else $error("imem_latency_timer: start while busy");

endmodule

// File: hdl/imem_rd_if.sv
// Instruction memory read channel
`timescale 1ns/1ps
`include "fetch_defs.svh"

interface imem_rd_if;

  // Address phase
  logic arvalid;
  logic arready;
  logic [`FETCH_DATA_WIDTH-1:0] araddr;

  // Data phase
  logic rvalid;
  logic rready;
  logic [31:0] rdata;

  modport fetch (
    output arvalid,
    output araddr,
    output rready,
    input  arready,
    input  rvalid,
    input  rdata
  );

  modport mem (
    input  arvalid,
    input  araddr,
    input  rready,
    output arready,
    output rvalid,
    output rdata
  );

endinterface

// File: hdl/imem_rom.sv
// Instruction memory with load port
`timescale 1ns/1ps
`include "fetch_defs.svh"

module imem_rom (
  input  logic        clk,
  input  logic        rst,
  input  logic        load_en,
  input  logic [7:0]  load_addr,
  input  logic [31:0] load_data,
  imem_rd_if.mem      rd
);

  localparam int IDX_W = $clog2(`FETCH_IMEM_WORDS);

  logic [31:0] mem [`FETCH_IMEM_WORDS];

  logic [`FETCH_DATA_WIDTH-1:0] offset;
  logic [IDX_W-1:0]             idx_q;
  logic                         hit_q;
  logic                         pending_q;
  logic                         ar_hs;
  logic                         r_hs;
  logic                         lat_done;

  // Byte offset from the base of the memory
  assign offset = rd.araddr - `FETCH_RESET_PC;
  assign ar_hs  = rd.arvalid && rd.arready;
  assign r_hs   = rd.rvalid && rd.rready;

  // Program load, done while the core sits in reset
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // Word index of the accepted address
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      idx_q <= offset[IDX_W+1:2];
      hit_q <= (offset >> 2) < `FETCH_IMEM_WORDS;
    end
  end

  // One read in flight, from address accept until data accept
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pending_q <= 1'b0;
    end else if (ar_hs) begin
      pending_q <= 1'b1;
    end else if (r_hs) begin
      pending_q <= 1'b0;
    end
  end

  imem_latency_timer timer_i (
    .clk   (clk),
    .rst   (rst),
    .start (ar_hs),
    .ack   (r_hs),
    .done  (lat_done)
  );

  assign rd.arready = !pending_q;
  assign rd.rvalid  = lat_done;
  // Out of range reads return zero
  assign rd.rdata   = hit_q ? mem[idx_q] : 32'h0;

  rvalid_hold_a : assert property (
    @(posedge clk) disable iff (rst)
    rd.rvalid && !rd.rready |=> rd.rvalid && $stable(rd.rdata)
  ) else $error("imem_rom: rvalid dropped or rdata changed before rready");

endmodule

// File: hdl/pc_unit.sv
// Program counter
`timescale 1ns/1ps
`include "fetch_defs.svh"

module pc_unit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         pc_wen,
  input  fetch_pkg::pc_sel_e           pc_sel,
  input  logic [`FETCH_DATA_WIDTH-1:0] jump_reg_target,
  input  logic [`FETCH_DATA_WIDTH-1:0] br_target,
  input  logic [`FETCH_DATA_WIDTH-1:0] jmp_target,
  output logic [`FETCH_DATA_WIDTH-1:0] pc
);

  logic [`FETCH_DATA_WIDTH-1:0] pc_q;
  logic [`FETCH_DATA_WIDTH-1:0] pc_plus_step;
  logic [`FETCH_DATA_WIDTH-1:0] pc_next;

  assign pc_plus_step = pc_q + `FETCH_PC_STEP;

  // Next PC mux, driven by the write-back select
  always_comb begin
    case (pc_sel)
      fetch_pkg::PC_SEQ:  pc_next = pc_plus_step;
      fetch_pkg::PC_JALR: pc_next = jump_reg_target;
      fetch_pkg::PC_BR:   pc_next = br_target;
      fetch_pkg::PC_JAL:  pc_next = jmp_target;
      fetch_pkg::PC_TRAP: pc_next = `FETCH_TRAP_VEC;
      default:            pc_next = pc_plus_step;
    endcase
  end

  // Only write-back moves the PC
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (pc_wen) begin
      pc_q <= pc_next;
    end
  end

  assign pc = pc_q;

  // Targets come from outside, so a misaligned one would show up here
  pc_word_aligned_a : assert property (
    @(posedge clk) disable iff (rst)
    pc_q[1:0] == 2'b00
  ) else $error("pc_unit: pc %h not word aligned", pc_q);

endmodule

// File: verification/fetch_checker.sv
// Fetch stage result checker
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] pc,
  input  logic [31:0] inst,
  input  logic        inst_valid,
  input  logic        idu_ready,
  input  logic        halt,
  input  logic [31:0] exp_pc,
  input  logic [31:0] exp_inst,
  input  int          test_idx,
  input  logic        halt_check_end,
  output int          pass_cnt,
  output int          fail_cnt
);

  logic        stalled_q;
  logic [31:0] held_pc;
  logic [31:0] held_inst;
  logic        ebreak_taken_q;
  logic        halted_q;
  int          test_errs;

  task automatic close_test(input string what);
    if (test_errs == 0) begin
      $display("test %0d %s pass pc %h inst %h", test_idx, what, pc, inst);
      pass_cnt++;
    end else begin
      $display("test %0d %s fail with %0d errors", test_idx, what, test_errs);
      fail_cnt++;
    end
    test_errs = 0;
  endtask

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      pass_cnt       = 0;
      fail_cnt       = 0;
      test_errs      = 0;
      stalled_q      = 1'b0;
      ebreak_taken_q = 1'b0;
      halted_q       = 1'b0;
    end else begin
      // Word under back-pressure must not move
      if (stalled_q) begin
        if (inst_valid !== 1'b1) begin
          $display("error inst_valid got %h expected 1 while stalled", inst_valid);
          test_errs++;
        end
        if (pc !== held_pc) begin
          $display("error pc got %h expected %h while stalled", pc, held_pc);
          test_errs++;
        end
        if (inst !== held_inst) begin
          $display("error inst got %h expected %h while stalled", inst, held_inst);
          test_errs++;
        end
      end
      // halt rises on the edge that accepts ebreak
      if (ebreak_taken_q) begin
        halted_q       = 1'b1;
        ebreak_taken_q = 1'b0;
      end
      if (halted_q) begin
        if (halt !== 1'b1) begin
          $display("error halt got %h expected 1", halt);
          test_errs++;
        end
      end else if (halt !== 1'b0) begin
        $display("error halt got %h expected 0 before ebreak", halt);
        test_errs++;
      end
      if (halted_q && inst_valid !== 1'b0) begin
        $display("error inst_valid got %h expected 0 after halt", inst_valid);
        test_errs++;
      end
      if (inst_valid === 1'b1 && idu_ready === 1'b1) begin
        if (pc !== exp_pc) begin
          $display("error pc got %h expected %h", pc, exp_pc);
          test_errs++;
        end
        if (inst !== exp_inst) begin
          $display("error inst got %h expected %h", inst, exp_inst);
          test_errs++;
        end
        ebreak_taken_q = (exp_inst === `FETCH_EBREAK);
        close_test("fetch");
      end
      if (halt_check_end) begin
        close_test("halt");
      end
      stalled_q = (inst_valid === 1'b1) && (idu_ready !== 1'b1);
      held_pc   = pc;
      held_inst = inst;
    end
  end

endmodule

// File: verification/fetch_tb.sv
// Fetch stage testbench
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_tb;

  localparam int NROWS         = 8;
  localparam int WORDS         = `FETCH_IMEM_WORDS;
  localparam int EBREAK_IDX    = 200;
  localparam int VALID_TIMEOUT = 200;
  localparam int HALT_TIMEOUT  = 10;
  localparam int HALT_WINDOW   = 50;

  typedef struct {
    fetch_pkg::pc_sel_e sel;
    logic [31:0]        jalr_tgt;
    logic [31:0]        br_tgt;
    logic [31:0]        jal_tgt;
    int                 hold;
    logic [31:0]        exp_next;
  } row_t;

  logic               clk;
  logic               rst;
  fetch_pkg::pc_sel_e pc_sel;
  logic [31:0]        jump_reg_target;
  logic [31:0]        br_target;
  logic [31:0]        jmp_target;
  logic               pc_wen;
  logic               load_en;
  logic [7:0]         load_addr;
  logic [31:0]        load_data;
  logic               idu_ready;
  logic [31:0]        pc;
  logic [31:0]        inst;
  logic               inst_valid;
  logic               halt;

  logic [31:0] exp_pc;
  logic [31:0] exp_inst;
  int          test_idx;
  logic        halt_check_end;
  int          pass_cnt;
  int          fail_cnt;
  int          timeouts;
  logic [31:0] mem_copy [WORDS];
  row_t        rows [NROWS];

  fetch_top dut_i (.*);
  fetch_checker chk_i (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Random words with an ADDI opcode, plus one ebreak
  task automatic build_program;
    logic [31:0] seed;
    int i;
    seed = 32'hd032dae9;
    for (i = 0; i < WORDS; i++) begin
      seed        = xorshift32(seed);
      mem_copy[i] = {seed[31:7], 7'h13};
    end
    mem_copy[EBREAK_IDX] = `FETCH_EBREAK;
  endtask

  task automatic build_table;
    rows[0] = '{fetch_pkg::PC_SEQ, 32'h8000_0010, 32'h8000_0020, 32'h8000_0030, 0, 32'h8000_0004};
    rows[1] = '{fetch_pkg::PC_SEQ, 32'h8000_0014, 32'h8000_0024, 32'h8000_0034, 3, 32'h8000_0008};
    rows[2] = '{fetch_pkg::PC_JALR, 32'h8000_0040, 32'h8000_0080, 32'h8000_00c0, 0, 32'h8000_0040};
    rows[3] = '{fetch_pkg::PC_BR, 32'h8000_0044, 32'h8000_0088, 32'h8000_00cc, 2, 32'h8000_0088};
    rows[4] = '{fetch_pkg::PC_JAL, 32'h8000_0048, 32'h8000_008c, 32'h8000_00d0, 0, 32'h8000_00d0};
    rows[5] = '{fetch_pkg::PC_SEQ, 32'h8000_004c, 32'h8000_0090, 32'h8000_00e4, 1, 32'h8000_00d4};
    rows[6] = '{fetch_pkg::PC_TRAP, 32'h8000_0050, 32'h8000_0094, 32'h8000_00e8, 4, 32'h8000_0100};
    // Last jump lands on the ebreak word
    rows[7] = '{fetch_pkg::PC_JAL, 32'h8000_0054, 32'h8000_0098, 32'h8000_0320, 0, 32'h8000_0320};
  endtask

  task automatic load_program;
    int i;
    for (i = 0; i < WORDS; i++) begin
      @(posedge clk);
      #1;
      load_en   = 1'b1;
      load_addr = i[7:0];
      load_data = mem_copy[i];
    end
    @(posedge clk);
    #1 load_en = 1'b0;
  endtask

  task automatic set_expected(input int idx, input logic [31:0] addr);
    logic [31:0] word_idx;
    word_idx = (addr - `FETCH_RESET_PC) >> 2;
    test_idx = idx;
    exp_pc   = addr;
    exp_inst = (word_idx < WORDS) ? mem_copy[word_idx] : 32'h0;
  endtask

  task automatic wait_inst_valid(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < VALID_TIMEOUT; n++) begin
      if (inst_valid === 1'b1) begin
        ok = 1'b1;
        break;
      end
      @(posedge clk);
      #1;
    end
    if (!ok) begin
      $display("timeout waiting for inst_valid in test %0d", test_idx);
      timeouts++;
    end
  endtask

  task automatic wait_halt(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < HALT_TIMEOUT; n++) begin
      if (halt === 1'b1) begin
        ok = 1'b1;
        break;
      end
      @(posedge clk);
      #1;
    end
    if (!ok) begin
      $display("timeout waiting for halt after the ebreak was accepted");
      timeouts++;
    end
  endtask

  // Stall the decoder side, then take the word
  task automatic accept_inst(input int hold);
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    idu_ready = 1'b1;
    @(posedge clk);
    #1 idu_ready = 1'b0;
  endtask

  task automatic pulse_pc_wen(input row_t r);
    pc_sel          = r.sel;
    jump_reg_target = r.jalr_tgt;
    br_target       = r.br_tgt;
    jmp_target      = r.jal_tgt;
    pc_wen          = 1'b1;
    @(posedge clk);
    #1 pc_wen = 1'b0;
  endtask

  task automatic end_run;
    $display("tests passed %0d failed %0d timeouts %0d", pass_cnt, fail_cnt, timeouts);
    if (fail_cnt == 0 && timeouts == 0 && pass_cnt == NROWS + 2) begin
      $display("RESULT: PASS");
    end else begin
      if (pass_cnt + fail_cnt != NROWS + 2) begin
        $display("only %0d of %0d tests completed", pass_cnt + fail_cnt, NROWS + 2);
      end
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    int r;
    bit ok;
    clk             = 1'b0;
    rst             = 1'b1;
    pc_sel          = fetch_pkg::PC_SEQ;
    jump_reg_target = '0;
    br_target       = '0;
    jmp_target      = '0;
    pc_wen          = 1'b0;
    load_en         = 1'b0;
    load_addr       = '0;
    load_data       = '0;
    idu_ready       = 1'b0;
    halt_check_end  = 1'b0;
    timeouts        = 0;
    ok              = 1'b1;
    build_program();
    build_table();
    set_expected(0, `FETCH_RESET_PC);
    // Reset covers the program load and five more cycles
    load_program();
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    for (r = 0; r < NROWS; r++) begin
      wait_inst_valid(ok);
      if (!ok) break;
      accept_inst(rows[r].hold);
      pulse_pc_wen(rows[r]);
      set_expected(r + 1, rows[r].exp_next);
    end
    if (ok) begin
      wait_inst_valid(ok);
    end
    if (ok) begin
      accept_inst(0);
      wait_halt(ok);
    end
    // A pc_wen while halted must not start a fetch
    if (ok) begin
      test_idx = NROWS + 1;
      pulse_pc_wen(rows[0]);
      repeat (HALT_WINDOW) @(posedge clk);
      #1 halt_check_end = 1'b1;
      @(posedge clk);
      #1 halt_check_end = 1'b0;
    end
    end_run();
  end

endmodule
